//--- rtl/intc_pkg.sv
package intc_pkg;

    // eight request lines, eight priority queues
    parameter int NUM_SRC    = 8;
    parameter int NUM_LEVELS = 8;

    typedef logic [2:0] src_id_t;
    typedef logic [2:0] level_t;

    // processor status word, priority sits in bits 7..5
    typedef struct packed {
        logic [7:0] upper;
        level_t     level;
        logic [4:0] lower;
    } psw_t;

    // one queued interrupt: fixed vector plus the source that raised it
    typedef struct packed {
        logic [7:0] vector;
        src_id_t    src;
    } irq_entry_t;

    // fixed vectors, indexed by source number
    localparam logic [7:0] VECTOR_TABLE [NUM_SRC] = '{
        8'hC2, 8'hC6, 8'hCA, 8'hCE, 8'hD2, 8'hD6, 8'hEE, 8'hF2
    };

endpackage

//--- rtl/intc_level_fifo.sv
`timescale 1ns/1ps

module intc_level_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  intc_pkg::irq_entry_t wr_entry,
    input  logic                pop,
    output intc_pkg::irq_entry_t head,
    output logic                empty,
    output logic                full
);
    import intc_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    irq_entry_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // one bit wider than the pointers so full and empty differ
    logic [PTR_W:0]   count;

    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));

    // show-ahead: oldest entry is always on head
    assign head = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // write and pop together leave occupancy unchanged
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/intc_capture.sv
`timescale 1ns/1ps

module intc_capture (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [intc_pkg::NUM_SRC-1:0]                 irq_req,
    input  intc_pkg::psw_t [intc_pkg::NUM_SRC-1:0]       psw,
    input  logic                                         read,
    input  logic [intc_pkg::NUM_LEVELS-1:0]              full,
    output logic [intc_pkg::NUM_LEVELS-1:0]              wr_en,
    output intc_pkg::irq_entry_t                         wr_entry,
    output logic [intc_pkg::NUM_SRC-1:0]                 irq_ack
);
    import intc_pkg::*;

    logic [NUM_SRC-1:0] eligible;
    logic [NUM_SRC-1:0] ack_next;
    src_id_t            win;
    logic               found;

    // drop requests whose level queue has no room, and all of them during a read
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            eligible[i] = irq_req[i] && !full[psw[i].level] && !read;
        end
    end

    // highest-numbered eligible source wins
    always_comb begin
        win   = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (eligible[i]) begin
                win   = src_id_t'(i);
                found = 1'b1;
            end
        end
    end

    // entry is shared by all queues, only one wr_en goes high
    assign wr_entry.vector = VECTOR_TABLE[win];
    assign wr_entry.src    = win;

    always_comb begin
        wr_en    = '0;
        ack_next = '0;
        if (found) begin
            wr_en[psw[win].level] = 1'b1;
            ack_next[win]         = 1'b1;
        end
    end

    // ack pulse lands in the cycle after the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_ack <= '0;
        end else begin
            irq_ack <= ack_next;
        end
    end

endmodule

//--- rtl/intc_dispatch.sv
`timescale 1ns/1ps

module intc_dispatch (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          read,
    input  logic [intc_pkg::NUM_LEVELS-1:0]               empty,
    input  intc_pkg::irq_entry_t [intc_pkg::NUM_LEVELS-1:0] head,
    output logic [intc_pkg::NUM_LEVELS-1:0]               pop,
    output intc_pkg::irq_entry_t                          vec_out,
    output logic                                          vec_valid,
    output logic                                          irq_pending
);
    import intc_pkg::*;

    level_t sel_lvl;
    logic   any_work;
    logic   take;

    // priority encoder, highest non-empty level last so it wins
    always_comb begin
        sel_lvl = '0;
        for (int l = 0; l < NUM_LEVELS; l++) begin
            if (!empty[l]) begin
                sel_lvl = level_t'(l);
            end
        end
    end

    assign any_work    = ~&empty;
    assign irq_pending = any_work;
    assign take        = read && any_work;

    always_comb begin
        pop = '0;
        if (take) begin
            pop[sel_lvl] = 1'b1;
        end
    end

    // single-cycle strobe per popped entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vec_valid <= 1'b0;
        end else begin
            vec_valid <= take;
        end
    end

    // holds the last popped entry when a read finds nothing
    always_ff @(posedge clk) begin
        if (take) begin
            vec_out <= head[sel_lvl];
        end
    end

endmodule

//--- rtl/intc_top.sv
`timescale 1ns/1ps

module intc_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [intc_pkg::NUM_SRC-1:0]           irq_req,
    input  intc_pkg::psw_t [intc_pkg::NUM_SRC-1:0] psw,
    input  logic                                   read,
    output logic [intc_pkg::NUM_SRC-1:0]           irq_ack,
    output intc_pkg::irq_entry_t                   vec_out,
    output logic                                   vec_valid,
    output logic                                   irq_pending
);
    import intc_pkg::*;

    logic [NUM_LEVELS-1:0]             wr_en;
    logic [NUM_LEVELS-1:0]             full;
    logic [NUM_LEVELS-1:0]             empty;
    logic [NUM_LEVELS-1:0]             pop;
    irq_entry_t                        wr_entry;
    irq_entry_t [NUM_LEVELS-1:0]       head;

    intc_capture intc_capture_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .irq_req  (irq_req),
        .psw      (psw),
        .read     (read),
        .full     (full),
        .wr_en    (wr_en),
        .wr_entry (wr_entry),
        .irq_ack  (irq_ack)
    );

    // one queue per priority level
    for (genvar g = 0; g < NUM_LEVELS; g++) begin : gen_level
        intc_level_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) intc_level_fifo_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_en    (wr_en[g]),
            .wr_entry (wr_entry),
            .pop      (pop[g]),
            .head     (head[g]),
            .empty    (empty[g]),
            .full     (full[g])
        );
    end

    intc_dispatch intc_dispatch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .read        (read),
        .empty       (empty),
        .head        (head),
        .pop         (pop),
        .vec_out     (vec_out),
        .vec_valid   (vec_valid),
        .irq_pending (irq_pending)
    );

endmodule

//--- bench/intc_chk.sv
`timescale 1ns/1ps

module intc_chk (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            read,
    input logic [intc_pkg::NUM_LEVELS-1:0] wr_en,
    input logic [intc_pkg::NUM_LEVELS-1:0] full,
    input logic [intc_pkg::NUM_LEVELS-1:0] pop,
    input logic [intc_pkg::NUM_LEVELS-1:0] empty,
    input logic [intc_pkg::NUM_SRC-1:0]    irq_ack,
    input logic                            vec_valid
);

    int fail_count = 0;

    // one queue written and one popped per cycle at most
    one_write: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wr_en))
        else begin
            fail_count++;
            $error("wr_en has more than one bit set: %b", wr_en);
        end

    one_pop: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop))
        else begin
            fail_count++;
            $error("pop has more than one bit set: %b", pop);
        end

    no_overflow: assert property (@(posedge clk) disable iff (!rst_n) (wr_en & full) == '0)
        else begin
            fail_count++;
            $error("write into a full queue, wr_en %b full %b", wr_en, full);
        end

    no_underflow: assert property (@(posedge clk) disable iff (!rst_n) (pop & empty) == '0)
        else begin
            fail_count++;
            $error("pop from an empty queue, pop %b empty %b", pop, empty);
        end

    // back-to-back valid only for back-to-back reads
    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        vec_valid && $past(vec_valid) |-> $past(read) && $past(read, 2))
        else begin
            fail_count++;
            $error("vec_valid held without two reads in a row");
        end

    no_ack_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        |irq_ack |-> !$past(read))
        else begin
            fail_count++;
            $error("irq_ack %b follows a cycle with read high", irq_ack);
        end

endmodule

bind intc_top intc_chk intc_chk_inst (.*);

//--- bench/tb_intc.sv
`timescale 1ns/1ps

module tb_intc;
    import intc_pkg::*;

    localparam int FIFO_DEPTH   = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam string STIM_FILE = "bench/intc_input.txt";

    // one cycle of stimulus plus the results it should produce
    typedef struct packed {
        logic [NUM_SRC-1:0] req;
        logic [31:0]        levels;
        logic               rd;
        logic [NUM_SRC-1:0] ack;
        logic               pending;
        logic               valid;
        irq_entry_t         entry;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    logic [NUM_SRC-1:0]   irq_req;
    psw_t [NUM_SRC-1:0]   psw;
    logic                 read;
    logic [NUM_SRC-1:0]   irq_ack;
    irq_entry_t           vec_out;
    logic                 vec_valid;
    logic                 irq_pending;

    step_t steps[$];
    bit    loaded;
    int    cur_step;

    intc_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) intc_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_req     (irq_req),
        .psw         (psw),
        .read        (read),
        .irq_ack     (irq_ack),
        .vec_out     (vec_out),
        .vec_valid   (vec_valid),
        .irq_pending (irq_pending)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_ack(input string name, input logic [NUM_SRC-1:0] got,
                             input logic [NUM_SRC-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h at step %0d", name, got, exp, cur_step);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_entry(input string name, input irq_entry_t got, input irq_entry_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got vector %h src %h expected vector %h src %h at step %0d",
                     name, got.vector, got.src, exp.vector, exp.src, cur_step);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h at step %0d", name, got, exp, cur_step);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_req, f_lv, f_rd, f_ack, f_pend, f_vld, f_vec, f_src;
        step_t       s;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file bench/intc_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment lines and blank lines carry no step
            if (line.len() > 1 && line.substr(0, 1) != "//") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            f_req, f_lv, f_rd, f_ack, f_pend, f_vld, f_vec, f_src);
                if (n != 8) begin
                    abort_run("a stimulus line does not hold eight columns");
                end
                s.req          = f_req[NUM_SRC-1:0];
                s.levels       = f_lv;
                s.rd           = f_rd[0];
                s.ack          = f_ack[NUM_SRC-1:0];
                s.pending      = f_pend[0];
                s.valid        = f_vld[0];
                s.entry.vector = f_vec[7:0];
                s.entry.src    = f_src[2:0];
                steps.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_step(input step_t s);
        irq_req = s.req;
        read    = s.rd;
        // one hex digit per source with the level in its low three bits
        for (int i = 0; i < NUM_SRC; i++) begin
            psw[i].upper = 8'h5a;
            psw[i].level = s.levels[4*i +: 3];
            psw[i].lower = 5'h13;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = steps.size() * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;
        #(limit);
        $display("The run timed out after %0d ns without reaching its end", limit);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin : main
        rst_n    = 1'b0;
        irq_req  = '0;
        psw      = '0;
        read     = 1'b0;
        cur_step = 0;
        load_stimulus();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        check_ack("irq_ack", irq_ack, '0);
        check_valid("vec_valid", vec_valid, 1'b0);
        check_valid("irq_pending", irq_pending, 1'b0);
        rst_n = 1'b1;
        for (int k = 0; k < steps.size(); k++) begin
            cur_step = k + 1;
            drive_step(steps[k]);
            @(posedge clk);
            #1;
            check_ack("irq_ack", irq_ack, steps[k].ack);
            check_valid("vec_valid", vec_valid, steps[k].valid);
            check_valid("irq_pending", irq_pending, steps[k].pending);
            if (steps[k].valid) begin
                check_entry("vec_out", vec_out, steps[k].entry);
            end
            if (intc_top_inst.intc_chk_inst.fail_count != 0) begin
                abort_run("a bound checker assertion failed during this step");
            end
            #1;
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- bench/intc_input.txt
// req levels rd | expected: ack pending valid vector src
// levels: one hex digit per source, source 7 leftmost
// single request, then reads with and without work
01 00000003 0 01 1 0 00 0
00 00000003 1 00 0 1 C2 0
00 00000003 1 00 0 0 00 0
00 00000003 0 00 0 0 00 0
// sources 6, 4, 1 together, then drain by level
52 02050020 0 40 1 0 00 0
12 02050020 0 10 1 0 00 0
02 02050020 0 02 1 0 00 0
00 02050020 0 00 1 0 00 0
00 02050020 1 00 1 1 D2 4
00 02050020 1 00 1 1 EE 6
00 02050020 1 00 0 1 C6 1
00 02050020 1 00 0 0 00 0
// request held across a read, shortest round trip
08 00007000 1 00 0 0 00 0
08 00007000 0 08 1 0 00 0
00 00007000 1 00 0 1 CE 3
// fill level 1, source 2 gets through at level 6
80 10000600 0 80 1 0 00 0
80 10000600 0 80 1 0 00 0
80 10000600 0 80 1 0 00 0
80 10000600 0 80 1 0 00 0
84 10000600 0 04 1 0 00 0
80 10000600 0 00 1 0 00 0
80 10000600 1 00 1 1 CA 2
80 10000600 1 00 1 1 F2 7
80 10000600 0 80 1 0 00 0
00 10000600 1 00 1 1 F2 7
00 10000600 1 00 1 1 F2 7
00 10000600 1 00 1 1 F2 7
00 10000600 1 00 0 1 F2 7
00 10000600 1 00 0 0 00 0

//--- vlog.f
rtl/intc_pkg.sv
rtl/intc_level_fifo.sv
rtl/intc_capture.sv
rtl/intc_dispatch.sv
rtl/intc_top.sv
bench/intc_chk.sv
bench/tb_intc.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_intc
FILELIST = vlog.f
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+100
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
